// File: Makefile
# Verilator build and run of the trace encoder testbench
VERILATOR ?= verilator
TOP       ?= trdb_tb
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
verilog/trdb_pkg.sv
verilog/trdb_if.sv
verilog/trdb_qualifier.sv
verilog/trdb_priority.sv
verilog/trdb_packet_emitter.sv
verilog/trdb_encapsulator.sv
verilog/trdb_top.sv
verif/trdb_chk.sv
verif/trdb_tb.sv

// File: verif/trdb_chk.sv
// ################################################
// protocol assertions on the encoder outputs, bound to the top
// ################################################
`timescale 1ns/1ps
`default_nettype none

module trdb_chk (
    input logic            clk_i,
    input logic            arst_n_i,
    input logic            packet_valid_i,
    input trdb_pkg::plen_t packet_len_i
);

    // nothing leaves while the pipeline is held in reset
    a_quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !packet_valid_i)
        else $error("packet_valid_o high during reset");

    // header plus at least one payload byte
    a_min_len: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                packet_valid_i |-> packet_len_i >= 5'd2)
        else $error("packet_len_o %0d below two bytes", packet_len_i);

endmodule

bind trdb_top trdb_chk trdb_chk_inst (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .packet_valid_i (packet_valid_o),
    .packet_len_i   (packet_len_o)
);

`default_nettype wire

// File: verif/trdb_stim.txt
# valid enable iaddr priv is_branch taken exception interrupt cause tval is_jump
# then exp_valid exp_len exp_packet, all hex, one line per cycle
1 1 00001000 3 1 1 0 0 00 00000000 0 1 06 8006345
1 1 00001004 3 0 0 0 0 00 00000000 0 0 00 0
0 1 00001008 3 0 0 0 0 00 00000000 0 0 00 0
1 0 00001008 3 0 0 0 0 00 00000000 1 0 00 0
1 0 0000100c 3 0 0 1 0 02 00000000 0 0 00 0
1 1 00002000 3 0 0 0 0 00 00000000 0 1 06 10007345
# trap, then interrupt together with a privilege change, then context
1 1 00003000 3 0 0 1 0 02 deadbeef 0 1 0b 1bd5b7dde000060001774a
1 1 00004000 1 0 0 0 1 07 00000000 0 1 0b 80013b74a
1 1 00004004 3 0 0 0 0 00 00000000 0 1 02 3b41
# jump alone, three branches and a jump, two jumps back to back
1 1 00005000 3 0 0 0 0 00 00000000 1 1 06 1400245
1 1 00005004 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00005008 3 1 1 0 0 00 00000000 0 0 00 0
1 1 0000500c 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00006000 3 0 0 0 0 00 00000000 1 1 0b 1800000000028d4a
1 1 00007000 3 0 0 0 0 00 00000000 1 1 06 1c00245
1 1 00007100 3 0 0 0 0 00 00000000 1 1 06 1c40245
# 31 branches, even ones not taken, map flushes on the last
1 1 00008000 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00008004 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008008 3 1 0 0 0 00 00000000 0 0 00 0
1 1 0000800c 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008010 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00008014 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008018 3 1 0 0 0 00 00000000 0 0 00 0
1 1 0000801c 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008020 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00008024 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008028 3 1 0 0 0 00 00000000 0 0 00 0
1 1 0000802c 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008030 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00008034 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008038 3 1 0 0 0 00 00000000 0 0 00 0
1 1 0000803c 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008040 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00008044 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008048 3 1 0 0 0 00 00000000 0 0 00 0
1 1 0000804c 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008050 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00008054 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008058 3 1 0 0 0 00 00000000 0 0 00 0
1 1 0000805c 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008060 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00008064 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008068 3 1 0 0 0 00 00000000 0 0 00 0
1 1 0000806c 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008070 3 1 0 0 0 00 00000000 0 0 00 0
1 1 00008074 3 1 1 0 0 00 00000000 0 0 00 0
1 1 00008078 3 1 0 0 0 00 00000000 0 1 06 2aaaaaaafd45
# map is empty again, so a jump gives address only
1 1 00009000 3 0 0 0 0 00 00000000 1 1 06 2400245
0 1 00009004 3 0 0 0 0 00 00000000 0 0 00 0

// File: verif/trdb_tb.sv
// ################################################
// testbench for the trace encoder: replays the stim file
// one line per cycle and checks each packet 4 cycles later
// ################################################
`timescale 1ns/1ps
`default_nettype none

module trdb_tb;

    localparam int unsigned XLEN      = 32;
    localparam int unsigned PKT_W     = 2*XLEN + 24;
    localparam int          LATENCY   = 4;  // drive edge to packet_valid_o
    localparam string       STIM_FILE = "verif/trdb_stim.txt";

    // one stim line: core inputs, then the expected result
    typedef struct packed {
        logic              valid;
        logic              enable;
        logic [XLEN-1:0]   iaddr;
        trdb_pkg::priv_t   priv;
        logic              is_branch;
        logic              taken;
        logic              exception;
        logic              interrupt;
        trdb_pkg::cause_t  cause;
        logic [XLEN-1:0]   tval;
        logic              is_jump;
        logic              exp_valid;
        trdb_pkg::plen_t   exp_len;
        logic [PKT_W-1:0]  exp_pkt;
    } stim_t;

    logic             clk_i;
    logic             arst_n_i;
    logic             valid_i;
    logic             enable_i;
    logic [XLEN-1:0]  iaddr_i;
    trdb_pkg::priv_t  priv_i;
    logic             is_branch_i;
    logic             branch_taken_i;
    logic             exception_i;
    logic             interrupt_i;
    trdb_pkg::cause_t cause_i;
    logic [XLEN-1:0]  tval_i;
    logic             is_jump_i;
    logic             packet_valid_o;
    trdb_pkg::plen_t  packet_len_o;
    logic [PKT_W-1:0] packet_o;

    stim_t stim_q[$];     // whole file, loaded before reset ends
    int    errors = 0;
    int    checks = 0;
    bit    loaded = 1'b0; // starts the watchdog

    trdb_top #(.XLEN(XLEN)) trdb_top_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .valid_i        (valid_i),
        .enable_i       (enable_i),
        .iaddr_i        (iaddr_i),
        .priv_i         (priv_i),
        .is_branch_i    (is_branch_i),
        .branch_taken_i (branch_taken_i),
        .exception_i    (exception_i),
        .interrupt_i    (interrupt_i),
        .cause_i        (cause_i),
        .tval_i         (tval_i),
        .is_jump_i      (is_jump_i),
        .packet_valid_o (packet_valid_o),
        .packet_len_o   (packet_len_o),
        .packet_o       (packet_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i; // 4 ns period
    end

    // reads all data lines, comment lines scan as zero fields
    task automatic load_stim(output bit ok);
        int          fd;
        int          n;
        string       line;
        stim_t       s;
        logic [31:0] v, en, ia, pr, br, tk, ex, it;
        logic [31:0] ca, tv, jm, ev, el;
        logic [PKT_W-1:0] ep;
        ok = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
            ok = 1'b0;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            v, en, ia, pr, br, tk, ex, it, ca, tv, jm, ev, el, ep);
                if (n == 14) begin
                    s = '{valid: v[0], enable: en[0], iaddr: ia, priv: pr[1:0],
                          is_branch: br[0], taken: tk[0], exception: ex[0],
                          interrupt: it[0], cause: ca[4:0], tval: tv, is_jump: jm[0],
                          exp_valid: ev[0], exp_len: el[4:0], exp_pkt: ep};
                    stim_q.push_back(s);
                end else if (n > 0) begin
                    $display("malformed stimulus line: %s", line);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
            if (stim_q.size() == 0) begin
                $display("stimulus file %s holds no data lines", STIM_FILE);
                ok = 1'b0;
            end
        end
    endtask

    task automatic drive(input stim_t s);
        valid_i        <= s.valid;
        enable_i       <= s.enable;
        iaddr_i        <= s.iaddr;
        priv_i         <= s.priv;
        is_branch_i    <= s.is_branch;
        branch_taken_i <= s.taken;
        exception_i    <= s.exception;
        interrupt_i    <= s.interrupt;
        cause_i        <= s.cause;
        tval_i         <= s.tval;
        is_jump_i      <= s.is_jump;
    endtask

    task automatic check_valid(input logic got, input logic exp, input int idx);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: line %0d packet_valid_o %b, expected %b",
                     $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_len(input trdb_pkg::plen_t got, input trdb_pkg::plen_t exp,
                             input int idx);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: line %0d packet_len_o %0d, expected %0d",
                     $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_packet(input logic [PKT_W-1:0] got, input logic [PKT_W-1:0] exp,
                                input int idx);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: line %0d packet_o %h, expected %h",
                     $time, idx, got, exp);
            errors++;
        end
    endtask

    // len and payload only mean something with the strobe
    task automatic compare(input int idx);
        stim_t s;
        s = stim_q[idx];
        check_valid(packet_valid_o, s.exp_valid, idx);
        if (s.exp_valid) begin
            check_len(packet_len_o, s.exp_len, idx);
            check_packet(packet_o, s.exp_pkt, idx);
        end
    endtask

    initial begin
        bit    ok;
        int    c;
        stim_t idle;
        idle           = '0;
        arst_n_i       = 1'b0;
        valid_i        = 1'b0;
        enable_i       = 1'b0;
        iaddr_i        = '0;
        priv_i         = '0;
        is_branch_i    = 1'b0;
        branch_taken_i = 1'b0;
        exception_i    = 1'b0;
        interrupt_i    = 1'b0;
        cause_i        = '0;
        tval_i         = '0;
        is_jump_i      = 1'b0;
        load_stim(ok);
        loaded = 1'b1;
        if (ok) begin
            repeat (4) @(posedge clk_i);
            arst_n_i <= 1'b1;
            for (c = 0; c < stim_q.size() + LATENCY; c++) begin
                @(posedge clk_i);
                if (c < stim_q.size()) drive(stim_q[c]);
                else drive(idle);                   // drain the pipeline
                @(negedge clk_i);                   // outputs settled
                if (c >= LATENCY) compare(c - LATENCY);
            end
        end else begin
            errors++;
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog, 20 spare cycles over the file length
    initial begin
        wait (loaded);
        #((stim_q.size() + 20) * 4);
        $display("timeout: run still going after %0d ns", (stim_q.size() + 20) * 4);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/trdb_encapsulator.sv
// ################################################
// stage 4: puts the header byte in front of the payload
// and registers the finished packet
// ################################################
`timescale 1ns/1ps
`default_nettype none

module trdb_encapsulator #(
    parameter int unsigned XLEN = 32
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic [2*XLEN+15:0]   payload_i,
    input  trdb_pkg::plen_t      payload_len_i,
    input  logic                 payload_valid_i,
    output logic [2*XLEN+23:0]   packet_o,
    output trdb_pkg::plen_t      packet_len_o,
    output logic                 packet_valid_o
);

    logic [7:0] header;

    // bit 7 spare, type in 6:5, payload bytes in 4:0
    assign header = {1'b0, trdb_pkg::TRACE_TYPE, payload_len_i};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= payload_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (payload_valid_i) begin
            packet_o     <= {payload_i, header};       // header goes out first
            packet_len_o <= payload_len_i + 5'd1;      // count the header byte too
        end
    end

endmodule

`default_nettype wire

// File: verilog/trdb_if.sv
// ################################################
// stage-to-stage bundles inside the encoder
// qualifier -> priority, priority -> emitter
// ################################################
`timescale 1ns/1ps
`default_nettype none

// one qualified retired instruction
interface trdb_instr_if #(
    parameter int unsigned XLEN = 32
);
    logic                valid;
    logic [XLEN-1:0]     iaddr;
    trdb_pkg::priv_t     priv;
    logic                exception;
    logic                interrupt;
    trdb_pkg::cause_t    cause;
    logic [XLEN-1:0]     tval;
    logic                is_branch;
    logic                branch_taken;
    logic                is_jump;      // uninferable discontinuity
    logic                first;        // first traced instruction
    logic                priv_change;  // privilege differs from last traced one

    modport src (
        output valid, iaddr, priv, exception, interrupt, cause, tval,
        output is_branch, branch_taken, is_jump, first, priv_change
    );
    modport dst (
        input valid, iaddr, priv, exception, interrupt, cause, tval,
        input is_branch, branch_taken, is_jump, first, priv_change
    );
endinterface

// packet request with everything the emitter needs
interface trdb_pkt_if #(
    parameter int unsigned XLEN = 32
);
    logic                              valid;
    trdb_pkg::trdb_format_e            format;
    trdb_pkg::trdb_f_sync_subformat_e  subformat;
    logic [XLEN-1:0]                   iaddr;
    trdb_pkg::priv_t                   priv;
    trdb_pkg::cause_t                  cause;
    logic                              interrupt;
    logic [XLEN-1:0]                   tval;
    logic                              branch;    // 1 = not a taken branch
    trdb_pkg::bcount_t                 bcount;
    trdb_pkg::bmap_t                   bmap;
    logic                              with_addr; // format 1 carries address

    modport src (
        output valid, format, subformat, iaddr, priv, cause, interrupt, tval,
        output branch, bcount, bmap, with_addr
    );
    modport dst (
        input valid, format, subformat, iaddr, priv, cause, interrupt, tval,
        input branch, bcount, bmap, with_addr
    );
endinterface

`default_nettype wire

// File: verilog/trdb_packet_emitter.sv
// ################################################
// stage 3: packs the packet fields from bit 0 upward and
// works out the payload length in bytes
// ################################################
`timescale 1ns/1ps
`default_nettype none

module trdb_packet_emitter #(
    parameter int unsigned XLEN = 32
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    trdb_pkt_if.dst               pkt_i,
    output logic [2*XLEN+15:0]    payload_o,
    output trdb_pkg::plen_t       payload_len_o,
    output logic                  payload_valid_o
);

    localparam int unsigned PW = 2*XLEN + 16; // widest payload is trap

    // bit count rounded up to whole bytes
    function automatic trdb_pkg::plen_t to_bytes(input int unsigned bits);
        return trdb_pkg::plen_t'((bits + 7) / 8);
    endfunction

    // field bit counts, notime and nocontext both in force
    localparam trdb_pkg::plen_t START_LEN   = to_bytes(2 + 2 + 1 + 2 + XLEN);
    localparam trdb_pkg::plen_t TRAP_LEN    = to_bytes(2 + 2 + 1 + 2 + 5 + 1 + 2*XLEN);
    localparam trdb_pkg::plen_t CONTEXT_LEN = to_bytes(2 + 2 + 2);
    localparam trdb_pkg::plen_t ADDR_LEN    = to_bytes(2 + XLEN + 3);
    localparam trdb_pkg::plen_t BMAP_A_LEN  = to_bytes(2 + 5 + 31 + XLEN + 3);
    localparam trdb_pkg::plen_t BMAP_LEN    = to_bytes(2 + 5 + 31);

    logic [PW-1:0]   payload_d;
    trdb_pkg::plen_t len_d;

    // concatenations read msb first, so the format ends up in bits 1:0
    always_comb begin
        payload_d = '0;
        len_d     = '0;
        case (pkt_i.format)
            trdb_pkg::F_SYNC: begin
                case (pkt_i.subformat)
                    trdb_pkg::SF_START: begin
                        payload_d = PW'({pkt_i.iaddr, pkt_i.priv, pkt_i.branch,
                                         pkt_i.subformat, pkt_i.format});
                        len_d     = START_LEN;
                    end
                    trdb_pkg::SF_TRAP: begin
                        payload_d = PW'({pkt_i.tval, pkt_i.iaddr, pkt_i.interrupt, pkt_i.cause,
                                         pkt_i.priv, pkt_i.branch, pkt_i.subformat,
                                         pkt_i.format});
                        len_d     = TRAP_LEN;
                    end
                    trdb_pkg::SF_CONTEXT: begin
                        payload_d = PW'({pkt_i.priv, pkt_i.subformat, pkt_i.format});
                        len_d     = CONTEXT_LEN;
                    end
                    default: ; // support packet is not generated
                endcase
            end
            trdb_pkg::F_ADDR_ONLY: begin
                // irreport, updiscon, notify all 0 above the address
                payload_d = PW'({3'b000, pkt_i.iaddr, pkt_i.format});
                len_d     = ADDR_LEN;
            end
            trdb_pkg::F_DIFF_DELTA: begin
                if (pkt_i.with_addr) begin
                    payload_d = PW'({3'b000, pkt_i.iaddr, pkt_i.bmap, pkt_i.bcount,
                                     pkt_i.format});
                    len_d     = BMAP_A_LEN;
                end else begin
                    payload_d = PW'({pkt_i.bmap, pkt_i.bcount, pkt_i.format});
                    len_d     = BMAP_LEN;
                end
            end
            default: ; // format 0 not built
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            payload_valid_o <= 1'b0;
        end else begin
            payload_valid_o <= pkt_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pkt_i.valid) begin
            payload_o     <= payload_d;
            payload_len_o <= len_d;
        end
    end

endmodule

`default_nettype wire

// File: verilog/trdb_pkg.sv
// ################################################
// shared types for the trace encoder pipeline
// packet format codes, field widths, fixed constants
// ################################################
`default_nettype none

package trdb_pkg;

    // packet format, sits in the low two bits of every payload
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'd0, // branch prediction / jtc, not built
        F_DIFF_DELTA = 2'd1, // branch map, with or without address
        F_ADDR_ONLY  = 2'd2, // address only
        F_SYNC       = 2'd3  // synchronisation, see subformat
    } trdb_format_e;

    // subformat of the sync packet
    typedef enum logic [1:0] {
        SF_START   = 2'd0, // tracing starts
        SF_TRAP    = 2'd1, // exception or interrupt
        SF_CONTEXT = 2'd2, // privilege change
        SF_SUPPORT = 2'd3  // encoder status, not built
    } trdb_f_sync_subformat_e;

    // privilege level as reported by the core
    typedef logic [1:0] priv_t;

    // exception / interrupt cause code
    typedef logic [4:0] cause_t;

    // number of branches held in the map
    typedef logic [4:0] bcount_t;

    // branch map, bit k set when branch k was not taken
    typedef logic [30:0] bmap_t;

    // packet length in bytes
    typedef logic [4:0] plen_t;

    // map holds this many branches before it must be flushed
    localparam bcount_t BMAP_FULL = 5'd31;

    // trace type code carried in the header byte
    localparam logic [1:0] TRACE_TYPE = 2'd2; // instruction trace

endpackage

`default_nettype wire

// File: verilog/trdb_priority.sv
// ################################################
// stage 2: keeps the branch map and decides which packet,
// if any, the current instruction needs
// ################################################
`timescale 1ns/1ps
`default_nettype none

module trdb_priority #(
    parameter int unsigned XLEN = 32
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    trdb_instr_if.dst  instr_i,
    trdb_pkt_if.src    pkt_o
);

    // RV32 / RV64 only, format 1 with address must fit the payload
    if (XLEN != 32 && XLEN != 64) begin : g_xlen_check
        $error("trdb_priority: XLEN must be 32 or 64");
    end

    trdb_pkg::bcount_t                bcount_q, bcount_nxt;
    trdb_pkg::bmap_t                  bmap_q, bmap_nxt;
    logic                             emit;      // a packet is needed
    logic                             with_addr;
    trdb_pkg::trdb_format_e           fmt;
    trdb_pkg::trdb_f_sync_subformat_e sfmt;

    // map including the current instruction
    always_comb begin
        bcount_nxt = bcount_q;
        bmap_nxt   = bmap_q;
        if (instr_i.is_branch) begin
            // upper bits are clear, so or-ing in the new outcome is enough
            bmap_nxt   = bmap_q | (trdb_pkg::bmap_t'(!instr_i.branch_taken) << bcount_q);
            bcount_nxt = bcount_q + 5'd1;
        end
    end

    // packet selection, highest priority first
    always_comb begin
        emit      = 1'b1;
        with_addr = 1'b1;
        fmt       = trdb_pkg::F_SYNC;
        sfmt      = trdb_pkg::SF_START;
        if (instr_i.first) begin
            sfmt = trdb_pkg::SF_START;
        end else if (instr_i.exception || instr_i.interrupt) begin
            sfmt = trdb_pkg::SF_TRAP;
        end else if (instr_i.priv_change) begin
            sfmt = trdb_pkg::SF_CONTEXT;
        end else if (instr_i.is_jump && bcount_nxt == '0) begin
            fmt = trdb_pkg::F_ADDR_ONLY;  // nothing in the map to report
        end else if (instr_i.is_jump) begin
            fmt = trdb_pkg::F_DIFF_DELTA; // map plus jump target
        end else if (bcount_nxt == trdb_pkg::BMAP_FULL) begin
            fmt       = trdb_pkg::F_DIFF_DELTA;
            with_addr = 1'b0;             // map full, flush without address
        end else begin
            emit = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bcount_q    <= '0;
            bmap_q      <= '0;
            pkt_o.valid <= 1'b0;
        end else begin
            pkt_o.valid <= instr_i.valid & emit;
            if (instr_i.valid) begin
                bcount_q <= emit ? '0 : bcount_nxt; // any packet empties the map
                bmap_q   <= emit ? '0 : bmap_nxt;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_i.valid) begin
            pkt_o.format    <= fmt;
            pkt_o.subformat <= sfmt;
            pkt_o.iaddr     <= instr_i.iaddr;
            pkt_o.priv      <= instr_i.priv;
            pkt_o.cause     <= instr_i.cause;
            pkt_o.interrupt <= instr_i.interrupt;
            pkt_o.tval      <= instr_i.tval;
            pkt_o.branch    <= ~(instr_i.is_branch & instr_i.branch_taken);
            pkt_o.bcount    <= bcount_nxt;
            pkt_o.bmap      <= bmap_nxt;
            pkt_o.with_addr <= with_addr;
        end
    end

endmodule

`default_nettype wire

// File: verilog/trdb_qualifier.sv
// ################################################
// stage 1: samples retired instructions while tracing is
// enabled and marks the first one and privilege changes
// ################################################
`timescale 1ns/1ps
`default_nettype none

module trdb_qualifier #(
    parameter int unsigned XLEN = 32
) (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              enable_i,
    input  logic              valid_i,
    input  logic [XLEN-1:0]   iaddr_i,
    input  trdb_pkg::priv_t   priv_i,
    input  logic              is_branch_i,
    input  logic              branch_taken_i,
    input  logic              exception_i,
    input  logic              interrupt_i,
    input  trdb_pkg::cause_t  cause_i,
    input  logic [XLEN-1:0]   tval_i,
    input  logic              is_jump_i,
    trdb_instr_if.src         instr_o
);

    logic            accept;      // instruction is traced this cycle
    logic            started_q;   // a traced instruction was seen since enable
    trdb_pkg::priv_t last_priv_q; // privilege of the last traced instruction

    assign accept = valid_i & enable_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            started_q     <= 1'b0;
            last_priv_q   <= '0;
            instr_o.valid <= 1'b0;
        end else begin
            instr_o.valid <= accept;
            if (!enable_i) begin
                started_q <= 1'b0; // next enabled instr is first again
            end else if (valid_i) begin
                started_q   <= 1'b1;
                last_priv_q <= priv_i;
            end
        end
    end

    // instruction fields, only meaningful with valid
    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_o.iaddr        <= iaddr_i;
            instr_o.priv         <= priv_i;
            instr_o.exception    <= exception_i;
            instr_o.interrupt    <= interrupt_i;
            instr_o.cause        <= cause_i;
            instr_o.tval         <= tval_i;
            instr_o.is_branch    <= is_branch_i;
            instr_o.branch_taken <= branch_taken_i;
            instr_o.is_jump      <= is_jump_i;
            instr_o.first        <= ~started_q;
            instr_o.priv_change  <= started_q & (priv_i != last_priv_q);
        end
    end

endmodule

`default_nettype wire

// File: verilog/trdb_top.sv
// ################################################
// trace encoder top: qualifier, priority, emitter and
// encapsulator in a fixed 4-cycle pipeline
// ################################################
`timescale 1ns/1ps
`default_nettype none

module trdb_top #(
    parameter int unsigned XLEN = 32
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               valid_i,        // one retired instruction
    input  logic               enable_i,       // tracing on, level
    input  logic [XLEN-1:0]    iaddr_i,
    input  trdb_pkg::priv_t    priv_i,
    input  logic               is_branch_i,
    input  logic               branch_taken_i,
    input  logic               exception_i,
    input  logic               interrupt_i,
    input  trdb_pkg::cause_t   cause_i,
    input  logic [XLEN-1:0]    tval_i,
    input  logic               is_jump_i,      // uninferable discontinuity
    output logic               packet_valid_o, // one-cycle strobe
    output trdb_pkg::plen_t    packet_len_o,   // bytes incl. header
    output logic [2*XLEN+23:0] packet_o
);

    logic [2*XLEN+15:0] payload;
    trdb_pkg::plen_t    payload_len;
    logic               payload_valid;

    trdb_instr_if #(.XLEN(XLEN)) instr_if ();
    trdb_pkt_if   #(.XLEN(XLEN)) pkt_if ();

    trdb_qualifier #(.XLEN(XLEN)) trdb_qualifier_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .enable_i       (enable_i),
        .valid_i        (valid_i),
        .iaddr_i        (iaddr_i),
        .priv_i         (priv_i),
        .is_branch_i    (is_branch_i),
        .branch_taken_i (branch_taken_i),
        .exception_i    (exception_i),
        .interrupt_i    (interrupt_i),
        .cause_i        (cause_i),
        .tval_i         (tval_i),
        .is_jump_i      (is_jump_i),
        .instr_o        (instr_if.src)
    );

    trdb_priority #(.XLEN(XLEN)) trdb_priority_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .instr_i  (instr_if.dst),
        .pkt_o    (pkt_if.src)
    );

    trdb_packet_emitter #(.XLEN(XLEN)) trdb_packet_emitter_inst (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .pkt_i           (pkt_if.dst),
        .payload_o       (payload),
        .payload_len_o   (payload_len),
        .payload_valid_o (payload_valid)
    );

    trdb_encapsulator #(.XLEN(XLEN)) trdb_encapsulator_inst (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .payload_i       (payload),
        .payload_len_i   (payload_len),
        .payload_valid_i (payload_valid),
        .packet_o        (packet_o),
        .packet_len_o    (packet_len_o),
        .packet_valid_o  (packet_valid_o)
    );

endmodule

`default_nettype wire
